//--- design/delay_pulse_generator.sv
`default_nettype none
`timescale 1ns/100ps
`include "dg_params.svh"

module delay_pulse_generator import dg_pkg::*; (
   input  wire logic               clk100,
   input  wire logic               hps_fpga_reset_n,
   input  wire logic               commit,
   input  wire dg_count_t          commit_interval,
   input  wire dg_pair_t           commit_pairs [`DG_NCHAN],
   output dg_count_t               active_interval,
   output dg_pair_t                active_pairs [`DG_NCHAN],
   output logic                    t0,
   output logic [`DG_NCHAN-1:0]    pins
);

   dg_count_t               cnt;                   // position in the period
   dg_count_t               cnt_next;
   dg_count_t               clamped_interval;
   dg_pair_t                pairs_next [`DG_NCHAN];
   logic [`DG_NCHAN-1:0]    pins_next;

   assign clamped_interval = (commit_interval < `DG_MIN_INTERVAL) ?
                             `DG_MIN_INTERVAL : commit_interval;

   // ========================================
   // next counter value and the pairs it runs with
   // ========================================
   always_comb begin
      if (commit) begin
         cnt_next = '0;                              // restart the period
      end else if (cnt >= active_interval - 32'd1) begin
         cnt_next = '0;                              // wrap
      end else begin
         cnt_next = cnt + 32'd1;
      end
      for (int k = 0; k < `DG_NCHAN; k++) begin
         pairs_next[k] = commit ? commit_pairs[k] : active_pairs[k];
      end
   end

   // window test per channel, delay included, delay plus width excluded
   always_comb begin
      dg_count_t   dly;
      dg_count_t   wid;
      logic [32:0] win_end;
      for (int k = 0; k < `DG_NCHAN; k++) begin
         dly          = pairs_next[k][63:32];
         wid          = pairs_next[k][31:0];
         win_end      = {1'b0, dly} + {1'b0, wid};   // no wrap on large values
         pins_next[k] = (cnt_next >= dly) && ({1'b0, cnt_next} < win_end);
      end
   end

   // ========================================
   // registered state and outputs
   // ========================================
   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         cnt             <= '0;
         t0              <= 1'b0;
         pins            <= '0;
         active_interval <= `DG_RESET_INTERVAL;
         for (int k = 0; k < `DG_NCHAN; k++) begin
            active_pairs[k] <= '0;
         end
      end else begin
         cnt  <= cnt_next;
         t0   <= (cnt_next == '0);                   // same count as the pins
         pins <= pins_next;
         if (commit) begin
            active_interval <= clamped_interval;
            for (int k = 0; k < `DG_NCHAN; k++) begin
               active_pairs[k] <= commit_pairs[k];
            end
         end
      end
   end

   // t0 is a single-cycle pulse, the floor keeps it well apart
   t0_single_cycle: assert property (
      @(posedge clk100) disable iff (!hps_fpga_reset_n)
      t0 |=> !t0
   );

   interval_floor: assert property (
      @(posedge clk100) disable iff (!hps_fpga_reset_n)
      commit |=> active_interval >= `DG_MIN_INTERVAL
   );

endmodule

`default_nettype wire

//--- design/delay_system_top.sv
`default_nettype none
`timescale 1ns/100ps
`include "dg_params.svh"

module delay_system_top import dg_pkg::*; (
   input  wire logic        clk100,
   input  wire logic        hps_fpga_reset_n,
   input  wire logic        host_write,
   input  wire logic [3:0]  host_addr,
   input  wire dg_word_t    host_wdata,
   output dg_word_t         host_rdata,
   output logic [5:0]       timing_out
);

   dg_count_t             user_interval;
   dg_page_t              prot_reg;          // requested protocol
   dg_view_e              view;
   dg_page_t              page;
   logic                  commit;
   logic                  store_write;
   logic [3:0]            store_index;
   logic [3:0]            pair_index;
   dg_pair_t              page_pairs [`DG_NCHAN];
   dg_pair_t              commit_pairs [`DG_NCHAN];
   dg_pair_t              active_pairs [`DG_NCHAN];
   dg_pair_t              viewed_pairs [`DG_NCHAN];
   dg_count_t             page_replicates;
   dg_count_t             active_interval;
   dg_count_t             viewed_interval;
   dg_stamp_t             timestamp;
   dg_count_t             t0_count;
   dg_page_t              active_prot;
   logic                  t0;
   logic [`DG_NCHAN-1:0]  pins;

   // ========================================
   // host write decode
   // ========================================
   assign pair_index  = host_addr - `DG_ADDR_PAIR0;
   assign commit      = host_write && host_addr == `DG_ADDR_CTRL && host_wdata[0];
   assign store_write = host_write && view == view_stored &&
                        ((host_addr >= `DG_ADDR_PAIR0 && host_addr <= 4'(`DG_NCHAN)) ||
                         host_addr == `DG_ADDR_REPL);
   assign store_index = (host_addr == `DG_ADDR_REPL) ? 4'(`DG_NCHAN) : pair_index;

   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         user_interval <= '0;
         prot_reg      <= '0;
         view          <= view_stored;
         page          <= '0;
      end else if (host_write) begin
         case (host_addr)
            `DG_ADDR_INTERVAL: user_interval <= host_wdata[31:0];
            `DG_ADDR_PROT:     prot_reg      <= host_wdata[1:0];
            `DG_ADDR_CTRL: begin
               view <= dg_view_e'(host_wdata[34]);   // flag bit 2
               page <= host_wdata[33:32];
            end
            default: ;
         endcase
      end
   end

   protocol_store protocol_store_inst (
      .clk100           (clk100),
      .hps_fpga_reset_n (hps_fpga_reset_n),
      .store_write      (store_write),
      .store_index      (store_index),
      .store_data       (host_wdata),
      .page             (page),
      .active_prot      (active_prot),
      .page_pairs       (page_pairs),
      .page_replicates  (page_replicates),
      .commit_pairs     (commit_pairs)
   );

   delay_pulse_generator delay_pulse_generator_inst (
      .clk100           (clk100),
      .hps_fpga_reset_n (hps_fpga_reset_n),
      .commit           (commit),
      .commit_interval  (user_interval),       // value before this write
      .commit_pairs     (commit_pairs),
      .active_interval  (active_interval),
      .active_pairs     (active_pairs),
      .t0               (t0),
      .pins             (pins)
   );

   t0_timestamp t0_timestamp_inst (
      .clk100           (clk100),
      .hps_fpga_reset_n (hps_fpga_reset_n),
      .t0               (t0),
      .prot_request     (prot_reg),
      .timestamp        (timestamp),
      .t0_count         (t0_count),
      .active_prot      (active_prot)
   );

   // ========================================
   // readback
   // ========================================
   assign viewed_interval = (view == view_active) ? active_interval : user_interval;

   always_comb begin
      for (int k = 0; k < `DG_NCHAN; k++) begin
         viewed_pairs[k] = (view == view_active) ? active_pairs[k] : page_pairs[k];
      end
   end

   always_comb begin
      host_rdata = '0;
      case (host_addr)
         `DG_ADDR_INTERVAL: host_rdata = {29'd0, view, page, viewed_interval};
         `DG_ADDR_REPL:     host_rdata = {32'd0, page_replicates};
         `DG_ADDR_STAMP:    host_rdata = timestamp;
         `DG_ADDR_PROT:     host_rdata = {t0_count, 30'd0, prot_reg};
         `DG_ADDR_CTRL:     host_rdata = {`DG_MODEL, `DG_REVISION};
         default: begin
            if (host_addr >= `DG_ADDR_PAIR0 && host_addr <= 4'(`DG_NCHAN)) begin
               host_rdata = viewed_pairs[pair_index];
            end
         end
      endcase
   end

   // active-low timing outputs, pins 7 and 8 stay internal
   assign timing_out[0] = ~pins[0];              // push
   assign timing_out[1] = ~pins[1];              // injection sector
   assign timing_out[2] = ~(pins[2] | pins[3]);  // ejection sectors
   assign timing_out[3] = ~(pins[4] | pins[5]);  // gates
   assign timing_out[4] = ~pins[6];              // adc delay
   assign timing_out[5] = t0;

   // a page write landing with a commit would race the generator load
   commit_vs_store: assert property (
      @(posedge clk100) disable iff (!hps_fpga_reset_n)
      !(commit && store_write)
   );

endmodule

`default_nettype wire

//--- design/dg_pkg.sv
`default_nettype none

package dg_pkg;

   // ========================================
   // widths that carry a meaning
   // ========================================
   typedef logic [31:0] dg_count_t;    // delays, widths, intervals, replicates
   typedef logic [63:0] dg_pair_t;     // delay in [63:32], width in [31:0]
   typedef logic [1:0]  dg_page_t;     // protocol or page number
   typedef logic [63:0] dg_word_t;     // host register word
   typedef logic [63:0] dg_stamp_t;    // clk100 cycle count

   // what the host readback shows
   typedef enum logic {
      view_stored = 1'b0,              // stored page and user interval
      view_active = 1'b1               // pairs and interval in the generator
   } dg_view_e;

endpackage

`default_nettype wire

//--- design/protocol_store.sv
`default_nettype none
`timescale 1ns/100ps
`include "dg_params.svh"

module protocol_store import dg_pkg::*; (
   input  wire logic      clk100,
   input  wire logic      hps_fpga_reset_n,
   input  wire logic      store_write,
   input  wire logic [3:0] store_index,
   input  wire dg_word_t  store_data,
   input  wire dg_page_t  page,
   input  wire dg_page_t  active_prot,
   output dg_pair_t       page_pairs [`DG_NCHAN],
   output dg_count_t      page_replicates,
   output dg_pair_t       commit_pairs [`DG_NCHAN]
);

   dg_pair_t  pair_mem [`DG_NPROT][`DG_NCHAN];   // four protocols of nine pairs
   dg_count_t repl_mem [`DG_NPROT];              // one replicate count per page

   // ========================================
   // host writes into the selected page
   // ========================================
   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         for (int p = 0; p < `DG_NPROT; p++) begin
            repl_mem[p] <= '0;
            for (int k = 0; k < `DG_NCHAN; k++) begin
               pair_mem[p][k] <= '0;
            end
         end
      end else if (store_write) begin
         if (store_index == 4'(`DG_NCHAN)) begin
            repl_mem[page] <= store_data[31:0];          // index 9 is replicates
         end else begin
            pair_mem[page][store_index] <= store_data;
         end
      end
   end

   // ========================================
   // two read ports: host page and active protocol
   // ========================================
   always_comb begin
      for (int k = 0; k < `DG_NCHAN; k++) begin
         page_pairs[k]   = pair_mem[page][k];
         commit_pairs[k] = pair_mem[active_prot][k];   // loaded by the generator on commit
      end
   end

   assign page_replicates = repl_mem[page];

   // index 10 to 15 would fall outside the page
   store_index_range: assert property (
      @(posedge clk100) disable iff (!hps_fpga_reset_n)
      store_write |-> store_index <= 4'(`DG_NCHAN)
   );

endmodule

`default_nettype wire

//--- design/t0_timestamp.sv
`default_nettype none
`timescale 1ns/100ps
`include "dg_params.svh"

module t0_timestamp import dg_pkg::*; (
   input  wire logic   clk100,
   input  wire logic   hps_fpga_reset_n,
   input  wire logic   t0,
   input  wire dg_page_t prot_request,
   output dg_stamp_t   timestamp,
   output dg_count_t   t0_count,
   output dg_page_t    active_prot
);

   dg_stamp_t clock_count;    // free running at 100 MHz

   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         clock_count <= '0;
      end else begin
         clock_count <= clock_count + 64'd1;
      end
   end

   // ========================================
   // capture at each t0
   // ========================================
   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         timestamp   <= '0;
         t0_count    <= '0;
         active_prot <= '0;
      end else if (t0) begin
         timestamp   <= clock_count;
         t0_count    <= t0_count + 32'd1;
         active_prot <= prot_request;                // used from the next commit on
      end
   end

endmodule

`default_nettype wire

//--- include/dg_params.svh
`ifndef DG_PARAMS_SVH
`define DG_PARAMS_SVH

// ========================================
// channel and protocol sizes
// ========================================
`define DG_NCHAN           9              // delay/width pairs per protocol
`define DG_NPROT           4              // stored protocols

// period limits in clk100 cycles
`define DG_RESET_INTERVAL  32'd100000     // 1 ms at 100 MHz
`define DG_MIN_INTERVAL    32'd1000       // 10 us floor

// identification words
`define DG_MODEL           32'h20210801
`define DG_REVISION        32'h00010002

// ========================================
// host register map
// ========================================
`define DG_ADDR_INTERVAL   4'd0           // flags and interval
`define DG_ADDR_PAIR0      4'd1           // pairs at 1 to 9
`define DG_ADDR_REPL       4'd12          // replicates of the page
`define DG_ADDR_STAMP      4'd13          // t0 timestamp
`define DG_ADDR_PROT       4'd14          // t0 count and protocol number
`define DG_ADDR_CTRL       4'd15          // flags and commit, model words on read

`endif

//--- src.f
+incdir+include
design/dg_pkg.sv
design/protocol_store.sv
design/delay_pulse_generator.sv
design/t0_timestamp.sv
design/delay_system_top.sv
tests/dg_checker.sv
tests/tb_delay_system.sv

//--- tests/dg_checker.sv
`default_nettype none
`timescale 1ns/100ps
`include "dg_params.svh"

module dg_checker import dg_pkg::*; (
   input  wire logic       clk100,
   input  wire logic       hps_fpga_reset_n,
   input  wire logic       host_write,
   input  wire logic [3:0] host_addr,
   input  wire dg_word_t   host_wdata,
   input  wire logic [5:0] timing_out,
   output int              error_count
);

   dg_pair_t                    store [`DG_NPROT][`DG_NCHAN];   // host side copy of the pages
   logic [`DG_NCHAN-1:0][63:0]  ref_pairs;                      // pairs since the last commit
   dg_count_t                   ref_interval;
   dg_count_t                   user_interval;
   dg_count_t                   offset;                         // cycles since t0
   dg_page_t                    page;
   dg_page_t                    prot_request;
   dg_page_t                    active_prot;
   logic                        view_is_active;
   logic                        running;                        // set by the first commit
   logic                        t0_seen = 1'b0;
   logic [5:0]                  expected;

   initial error_count = 0;

   // expected timing_out for one cycle offset after t0
   function automatic logic [5:0] expected_outputs(input dg_count_t ofs,
                                                   input logic [`DG_NCHAN-1:0][63:0] pairs);
      dg_count_t             delay;
      dg_count_t             width;
      logic [`DG_NCHAN-1:0]  pin;
      for (int k = 0; k < `DG_NCHAN; k++) begin
         delay  = pairs[k][63:32];
         width  = pairs[k][31:0];
         pin[k] = (ofs >= delay) && (ofs - delay < width);   // zero width never fires
      end
      return {ofs == 32'd0, ~pin[6], ~(pin[4] | pin[5]), ~(pin[2] | pin[3]), ~pin[1], ~pin[0]};
   endfunction

   // ========================================
   // reference model of the host registers
   // ========================================
   always @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         for (int p = 0; p < `DG_NPROT; p++) begin
            for (int k = 0; k < `DG_NCHAN; k++) begin
               store[p][k] <= '0;
            end
         end
         ref_pairs      <= '0;
         ref_interval   <= `DG_RESET_INTERVAL;
         user_interval  <= '0;
         offset         <= '0;
         page           <= '0;
         prot_request   <= '0;
         active_prot    <= '0;
         view_is_active <= 1'b0;
         running        <= 1'b0;
      end else begin
         if (t0_seen) active_prot <= prot_request;        // latched at each t0
         if (host_write) begin
            case (host_addr)
               `DG_ADDR_INTERVAL: user_interval <= host_wdata[31:0];
               `DG_ADDR_PROT:     prot_request  <= host_wdata[1:0];
               `DG_ADDR_CTRL: begin
                  view_is_active <= host_wdata[34];
                  page           <= host_wdata[33:32];
               end
               default: begin
                  if (!view_is_active && host_addr >= 4'd1 && host_addr <= 4'd9) begin
                     store[page][host_addr - 4'd1] <= host_wdata;
                  end
               end
            endcase
         end
         if (host_write && host_addr == `DG_ADDR_CTRL && host_wdata[0]) begin
            for (int k = 0; k < `DG_NCHAN; k++) begin
               ref_pairs[k] <= store[active_prot][k];
            end
            ref_interval <= (user_interval < `DG_MIN_INTERVAL) ? `DG_MIN_INTERVAL : user_interval;
            offset       <= '0;
            running      <= 1'b1;
         end else if (running) begin
            offset <= (offset + 32'd1 == ref_interval) ? 32'd0 : offset + 32'd1;
         end
      end
   end

   // compare mid cycle, outputs settled
   always @(negedge clk100) begin
      t0_seen <= timing_out[5];
      if (hps_fpga_reset_n === 1'b1) begin
         expected = running ? expected_outputs(offset, ref_pairs) : 6'b01_1111;
         if (timing_out !== expected) begin
            error_count++;
            $display("ERROR at %0t: timing_out %b, expected %b at offset %0d",
                     $time, timing_out, expected, offset);
         end
      end
   end

endmodule

`default_nettype wire

//--- tests/tb_delay_system.sv
`default_nettype none
`timescale 1ns/100ps
`include "dg_params.svh"

module tb_delay_system import dg_pkg::*; ();

   logic        clk100;
   logic        hps_fpga_reset_n;
   logic        host_write;
   logic [3:0]  host_addr;
   dg_word_t    host_wdata;
   dg_word_t    host_rdata;
   logic [5:0]  timing_out;
   integer      seed;
   int          tb_errors;
   int          checker_errors;
   int          cycles;
   int          t0_pulses;                       // t0 pulses seen on timing_out
   logic        timed_out;
   dg_pair_t    stored [`DG_NPROT][`DG_NCHAN];   // what each page should hold
   dg_word_t    rd;
   dg_word_t    stamp_a;

   initial clk100 = 1'b0;
   always #4 clk100 = ~clk100;                   // 8 ns period

   delay_system_top delay_system_top_inst (
      .clk100           (clk100),
      .hps_fpga_reset_n (hps_fpga_reset_n),
      .host_write       (host_write),
      .host_addr        (host_addr),
      .host_wdata       (host_wdata),
      .host_rdata       (host_rdata),
      .timing_out       (timing_out)
   );

   dg_checker dg_checker_inst (
      .clk100           (clk100),
      .hps_fpga_reset_n (hps_fpga_reset_n),
      .host_write       (host_write),
      .host_addr        (host_addr),
      .host_wdata       (host_wdata),
      .timing_out       (timing_out),
      .error_count      (checker_errors)
   );

   // flags in the upper word, commit in bit 0
   function automatic dg_word_t ctrl_word(input logic active, input dg_page_t pg, input logic go);
      return {29'd0, active, pg, 31'd0, go};
   endfunction

   // count of t0 pulses, compared with the count register
   always @(negedge clk100) begin
      if (hps_fpga_reset_n === 1'b1 && timing_out[5] === 1'b1) begin
         t0_pulses++;
      end
   end

   // ========================================
   // host access
   // ========================================
   task automatic write_reg(input logic [3:0] addr, input dg_word_t data);
      @(negedge clk100);
      host_write = 1'b1;
      host_addr  = addr;
      host_wdata = data;
      @(negedge clk100);
      host_write = 1'b0;
   endtask

   task automatic read_reg(input logic [3:0] addr, output dg_word_t data);
      @(negedge clk100);
      host_addr = addr;
      #1;                                        // combinational readback
      data = host_rdata;
   endtask

   task automatic check_read(input logic [3:0] addr, input dg_word_t expected);
      dg_word_t value;
      read_reg(addr, value);
      if (value !== expected) begin
         tb_errors++;
         $display("ERROR at %0t: address %0d read %h, expected %h", $time, addr, value, expected);
      end
   endtask

   task automatic wait_t0(input int limit, output int spacing);
      spacing = 0;
      if (timed_out) return;
      do begin
         @(negedge clk100);
         spacing++;
      end while (timing_out[5] !== 1'b1 && spacing <= limit);
      if (timing_out[5] !== 1'b1) begin
         timed_out = 1'b1;
         tb_errors++;
         $display("timeout: no t0 pulse within %0d cycles", limit);
      end
   endtask

   task automatic check_spacing(input int interval);
      int spacing;
      wait_t0(interval + 16, spacing);
      if (spacing != interval) begin
         tb_errors++;
         $display("ERROR at %0t: t0 spacing %0d, expected %0d", $time, spacing, interval);
      end
   endtask

   // random windows stay below 900 cycles, inside every interval used
   task automatic fill_page(input dg_page_t pg);
      dg_count_t delay;
      dg_count_t width;
      write_reg(`DG_ADDR_CTRL, ctrl_word(1'b0, pg, 1'b0));
      for (int k = 0; k < `DG_NCHAN; k++) begin
         delay         = $unsigned($random(seed)) % 500;
         width         = $unsigned($random(seed)) % 400;
         stored[pg][k] = {delay, width};
         write_reg(`DG_ADDR_PAIR0 + 4'(k), stored[pg][k]);
      end
   endtask

   // ========================================
   // stimulus
   // ========================================
   initial begin
      host_write       = 1'b0;
      host_addr        = '0;
      host_wdata       = '0;
      hps_fpga_reset_n = 1'b0;
      tb_errors        = 0;
      t0_pulses        = 0;
      timed_out        = 1'b0;
      seed             = 32'hae9b_222e;
      repeat (4) @(negedge clk100);
      hps_fpga_reset_n = 1'b1;

      // idle levels and identification
      @(negedge clk100);
      if (timing_out !== 6'b01_1111) begin
         tb_errors++;
         $display("ERROR at %0t: idle timing_out %b", $time, timing_out);
      end
      check_read(`DG_ADDR_CTRL, {`DG_MODEL, `DG_REVISION});

      // page 2 readback, then run protocol 2
      fill_page(2'd2);
      for (int k = 0; k < `DG_NCHAN; k++) check_read(`DG_ADDR_PAIR0 + 4'(k), stored[2][k]);
      write_reg(`DG_ADDR_REPL, 64'd3);
      check_read(`DG_ADDR_REPL, 64'd3);
      write_reg(`DG_ADDR_INTERVAL, 64'd2000);
      check_read(`DG_ADDR_INTERVAL, {29'd0, 1'b0, 2'd2, 32'd2000});
      write_reg(`DG_ADDR_PROT, 64'd2);
      write_reg(`DG_ADDR_CTRL, ctrl_word(1'b0, 2'd2, 1'b1));   // protocol 0, zero pairs
      check_spacing(2000);                                     // this t0 takes protocol 2
      write_reg(`DG_ADDR_CTRL, ctrl_word(1'b0, 2'd2, 1'b1));
      repeat (3) check_spacing(2000);

      // interval below the floor
      write_reg(`DG_ADDR_INTERVAL, 64'd200);
      write_reg(`DG_ADDR_CTRL, ctrl_word(1'b0, 2'd2, 1'b1));
      check_spacing(`DG_MIN_INTERVAL);
      write_reg(`DG_ADDR_CTRL, ctrl_word(1'b1, 2'd2, 1'b0));
      check_read(`DG_ADDR_INTERVAL, {29'd0, 1'b1, 2'd2, `DG_MIN_INTERVAL});

      // other page does not reach the pins, t0 count and timestamps
      fill_page(2'd1);
      wait_t0(1016, cycles);
      check_spacing(1000);
      read_reg(`DG_ADDR_STAMP, stamp_a);
      check_read(`DG_ADDR_PROT, {t0_pulses, 30'd0, 2'd2});
      wait_t0(1016, cycles);
      repeat (2) check_spacing(1000);
      read_reg(`DG_ADDR_STAMP, rd);
      if (rd - stamp_a !== 64'd3000) begin
         tb_errors++;
         $display("ERROR at %0t: timestamps %0d apart, expected 3000", $time, rd - stamp_a);
      end
      check_read(`DG_ADDR_PROT, {t0_pulses, 30'd0, 2'd2});

      // pair writes in the active view are dropped
      write_reg(`DG_ADDR_CTRL, ctrl_word(1'b1, 2'd2, 1'b0));
      for (int k = 0; k < `DG_NCHAN; k++) check_read(`DG_ADDR_PAIR0 + 4'(k), stored[2][k]);
      for (int k = 0; k < `DG_NCHAN; k++) begin
         write_reg(`DG_ADDR_PAIR0 + 4'(k), {$random(seed), $random(seed)});
      end
      write_reg(`DG_ADDR_CTRL, ctrl_word(1'b0, 2'd2, 1'b0));
      for (int k = 0; k < `DG_NCHAN; k++) check_read(`DG_ADDR_PAIR0 + 4'(k), stored[2][k]);
      write_reg(`DG_ADDR_CTRL, ctrl_word(1'b0, 2'd1, 1'b0));
      for (int k = 0; k < `DG_NCHAN; k++) check_read(`DG_ADDR_PAIR0 + 4'(k), stored[1][k]);
      wait_t0(1016, cycles);

      $display("closing report: %0d testbench errors, %0d checker errors",
               tb_errors, checker_errors);
      if (tb_errors == 0 && checker_errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
